// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/icache_pkg.sv
      - rtl/icache_way.sv
      - rtl/icache_way_select.sv
      - rtl/icache_ctrl.sv
      - rtl/icache_top.sv
  - target: test
    files:
      - verification/icache_tb.sv

// File: icache_top.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_way.sv
rtl/icache_way_select.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verification/icache_tb.sv

// File: rtl/icache_ctrl.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic [31:0]             req_addr,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output icache_pkg::word_t       rsp_data,
    output logic                    rd_en,
    output icache_pkg::index_t      rd_index,
    output icache_pkg::tag_t        cmp_tag,
    output logic                    word_sel,
    input  logic [`ICACHE_WAYS-1:0] way_valid,
    input  logic                    any_hit,
    input  logic                    hit_way,
    input  icache_pkg::word_t       hit_word,
    output logic [`ICACHE_WAYS-1:0] fill_en,
    output icache_pkg::index_t      fill_index,
    output icache_pkg::tag_t        fill_tag,
    output icache_pkg::line_t       fill_line,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic [31:0]             mem_req_addr,
    input  logic                    mem_rsp_valid,
    input  icache_pkg::line_t       mem_rsp_data
);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t next_state;

    // fields of the incoming address
    icache_pkg::tag_t        addr_tag;
    icache_pkg::index_t      addr_index;
    icache_pkg::offset_t     addr_offset;

    // request buffer
    icache_pkg::tag_t        req_tag;
    icache_pkg::index_t      req_index;
    icache_pkg::offset_t     req_offset;

    icache_pkg::word_t       rsp_data_q;
    logic [`ICACHE_SETS-1:0] lru;
    logic                    victim;
    logic                    accept;
    logic                    fill;

    assign addr_tag    = req_addr[31:`ICACHE_INDEX_W+`ICACHE_OFFSET_W];
    assign addr_index  = req_addr[`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:`ICACHE_OFFSET_W];
    assign addr_offset = req_addr[`ICACHE_OFFSET_W-1:0];

    assign accept = (state == icache_pkg::IDLE) && req_valid;
    assign fill   = (state == icache_pkg::REFILL) && mem_rsp_valid;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag    <= addr_tag;
            req_index  <= addr_index;
            req_offset <= addr_offset;
        end
    end

    // empty way first, way 0 before way 1, then the LRU way
    always_comb begin
        if (!way_valid[0]) begin
            victim = 1'b0;
        end else if (!way_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru[req_index];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (req_valid) begin
                    next_state = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                if (any_hit) begin
                    next_state = icache_pkg::RESPOND;
                end else begin
                    next_state = icache_pkg::MISS;
                end
            end
            icache_pkg::MISS: begin
                if (mem_req_ready) begin
                    next_state = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                // fill and re-read on the same edge
                if (mem_rsp_valid) begin
                    next_state = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::RESPOND: begin
                if (rsp_ready) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            default: begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::IDLE;
            lru   <= '0;
        end else begin
            state <= next_state;
            // point at the way not used
            if (state == icache_pkg::LOOKUP && any_hit) begin
                lru[req_index] <= ~hit_way;
            end
        end
    end

    // held through back-pressure
    always_ff @(posedge clk) begin
        if (state == icache_pkg::LOOKUP && any_hit) begin
            rsp_data_q <= hit_word;
        end
    end

    assign req_ready = (state == icache_pkg::IDLE);
    assign rsp_valid = (state == icache_pkg::RESPOND);
    assign rsp_data  = rsp_data_q;

    assign rd_en    = accept || fill;
    assign rd_index = (state == icache_pkg::IDLE) ? addr_index : req_index;
    assign cmp_tag  = req_tag;
    assign word_sel = req_offset[2];

    always_comb begin
        fill_en         = '0;
        fill_en[victim] = fill;
    end

    assign fill_index = req_index;
    assign fill_tag   = req_tag;
    assign fill_line  = mem_rsp_data;

    assign mem_req_valid = (state == icache_pkg::MISS);
    assign mem_req_addr  = {req_tag, req_index, {`ICACHE_OFFSET_W{1'b0}}};

endmodule

// File: rtl/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address split: tag | set index | byte offset
`define ICACHE_TAG_W    23
`define ICACHE_INDEX_W  6
`define ICACHE_OFFSET_W 3

// one LRU bit per set limits this to two ways
`define ICACHE_WAYS     2

// one set per index value
`define ICACHE_SETS     (1 << `ICACHE_INDEX_W)

`endif

// File: rtl/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

    // one instruction word
    typedef logic [31:0] word_t;

    // two words per line, word 0 in the low half
    typedef logic [63:0] line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

// File: rtl/icache_top.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top (
    input  logic              clk,
    input  logic              rst,
    // fetch side
    input  logic              req_valid,
    output logic              req_ready,
    input  logic [31:0]       req_addr,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output icache_pkg::word_t rsp_data,
    // memory side
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output logic [31:0]       mem_req_addr,
    input  logic              mem_rsp_valid,
    input  icache_pkg::line_t mem_rsp_data
);

    logic                    rd_en;
    icache_pkg::index_t      rd_index;
    icache_pkg::tag_t        cmp_tag;
    logic                    word_sel;
    logic [`ICACHE_WAYS-1:0] fill_en;
    icache_pkg::index_t      fill_index;
    icache_pkg::tag_t        fill_tag;
    icache_pkg::line_t       fill_line;

    logic [`ICACHE_WAYS-1:0] way_valid;
    logic [`ICACHE_WAYS-1:0] way_hit;
    icache_pkg::line_t       way_line [`ICACHE_WAYS];

    logic                    any_hit;
    logic                    hit_way;
    icache_pkg::word_t       hit_word;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_addr      (req_addr),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_data      (rsp_data),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .cmp_tag       (cmp_tag),
        .word_sel      (word_sel),
        .way_valid     (way_valid),
        .any_hit       (any_hit),
        .hit_way       (hit_way),
        .hit_word      (hit_word),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_way u_way (
            .clk        (clk),
            .rst        (rst),
            .rd_en      (rd_en),
            .rd_index   (rd_index),
            .cmp_tag    (cmp_tag),
            .fill_en    (fill_en[w]),
            .fill_index (fill_index),
            .fill_tag   (fill_tag),
            .fill_line  (fill_line),
            .valid      (way_valid[w]),
            .hit        (way_hit[w]),
            .line       (way_line[w])
        );
    end

    icache_way_select u_way_select (
        .hit      (way_hit),
        .line     (way_line),
        .word_sel (word_sel),
        .any_hit  (any_hit),
        .hit_way  (hit_way),
        .word     (hit_word)
    );

endmodule

// File: rtl/icache_way.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_way (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en,
    input  icache_pkg::index_t  rd_index,
    input  icache_pkg::tag_t    cmp_tag,
    input  logic                fill_en,
    input  icache_pkg::index_t  fill_index,
    input  icache_pkg::tag_t    fill_tag,
    input  icache_pkg::line_t   fill_line,
    output logic                valid,
    output logic                hit,
    output icache_pkg::line_t   line
);

    logic [`ICACHE_SETS-1:0] valid_bits;
    icache_pkg::tag_t        tag_mem  [`ICACHE_SETS];
    icache_pkg::line_t       data_mem [`ICACHE_SETS];

    logic                    valid_q;
    icache_pkg::tag_t        tag_q;
    icache_pkg::line_t       line_q;

    // a read in the same cycle as a fill of that set sees the new line
    logic                    fwd;

    assign fwd = fill_en && (fill_index == rd_index);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (fill_en) begin
                valid_bits[fill_index] <= 1'b1;
            end
            if (rd_en) begin
                valid_q <= fwd ? 1'b1 : valid_bits[rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_line;
        end
        if (rd_en) begin
            tag_q  <= fwd ? fill_tag : tag_mem[rd_index];
            line_q <= fwd ? fill_line : data_mem[rd_index];
        end
    end

    assign valid = valid_q;
    assign hit   = valid_q && (tag_q == cmp_tag);
    assign line  = line_q;

endmodule

// File: rtl/icache_way_select.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_way_select (
    input  logic [`ICACHE_WAYS-1:0] hit,
    input  icache_pkg::line_t       line [`ICACHE_WAYS],
    input  logic                    word_sel,
    output logic                    any_hit,
    output logic                    hit_way,
    output icache_pkg::word_t       word
);

    icache_pkg::line_t sel_line;

    assign any_hit = |hit;

    // at most one way hits, so a plain scan encodes it
    always_comb begin
        hit_way  = 1'b0;
        sel_line = line[0];
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit[w]) begin
                hit_way  = 1'(w);
                sel_line = line[w];
            end
        end
    end

    // offset bit 2 picks the upper word
    always_comb begin
        if (word_sel) begin
            word = sel_line[63:32];
        end else begin
            word = sel_line[31:0];
        end
    end

endmodule

// File: verification/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

    localparam int CLK_PERIOD       = 20;
    localparam int CYCLES_PER_FETCH = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] req_addr;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_data;
    logic        mem_req_valid;
    logic        mem_req_ready;
    logic [31:0] mem_req_addr;
    logic        mem_rsp_valid;
    logic [63:0] mem_rsp_data;

    // fetch list from the data file
    logic [31:0] fetch_addr [$];
    logic [31:0] fetch_word [$];
    logic        fetch_refill [$];
    logic        loaded = 1'b0;

    int          error_count   = 0;
    int          tests_run     = 0;
    int          tests_failed  = 0;
    int          mem_req_count = 0;
    logic [31:0] last_mem_addr;

    icache_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_addr      (req_addr),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic load_fetches(output bit ok);
        int          fd;
        string       text;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] f;
        ok = 1'b0;
        fd = $fopen("verification/icache_testdata.txt", "r");
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                // comment lines do not scan as three numbers
                if ($sscanf(text, "%h %h %h", a, w, f) == 3) begin
                    fetch_addr.push_back(a);
                    fetch_word.push_back(w);
                    fetch_refill.push_back(f[0]);
                end
            end
            $fclose(fd);
            ok = (fetch_addr.size() > 0);
        end
    endtask

    task automatic run_fetch(input int idx);
        logic [31:0] addr;
        logic [31:0] exp_word;
        logic        exp_refill;
        logic [31:0] held;
        int          errs;
        int          mem_before;
        int          cycles;
        int          stall;
        addr       = fetch_addr[idx];
        exp_word   = fetch_word[idx];
        exp_refill = fetch_refill[idx];
        errs       = error_count;
        mem_before = mem_req_count;
        stall      = $urandom % 4;
        req_valid <= 1'b1;
        req_addr  <= addr;
        @(posedge clk);
        while (req_ready !== 1'b1) begin
            @(posedge clk);
        end
        // accepting edge
        req_valid <= 1'b0;
        rsp_ready <= (stall == 0);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (rsp_valid !== 1'b1);
        held = rsp_data;
        if (rsp_data !== exp_word) begin
            report_error($sformatf("addr %h: data %h, expected %h", addr, rsp_data, exp_word));
        end
        if (!exp_refill && cycles != 2) begin
            report_error($sformatf("addr %h: hit answered after %0d cycles, expected 2",
                                   addr, cycles));
        end
        // hold the response back for a few cycles
        for (int k = 1; k <= stall; k++) begin
            if (k == stall) begin
                rsp_ready <= 1'b1;
            end
            @(posedge clk);
            if (rsp_valid !== 1'b1 || rsp_data !== held) begin
                report_error($sformatf("addr %h: response changed while stalled", addr));
            end
            if (req_ready !== 1'b0) begin
                report_error($sformatf("addr %h: req_ready high while stalled", addr));
            end
        end
        if ((mem_req_count - mem_before) != (exp_refill ? 1 : 0)) begin
            report_error($sformatf("addr %h: %0d memory requests, expected %0d", addr,
                                   mem_req_count - mem_before, exp_refill));
        end
        if (exp_refill && last_mem_addr !== {addr[31:3], 3'b000}) begin
            report_error($sformatf("addr %h: line request to %h", addr, last_mem_addr));
        end
        finish_test($sformatf("fetch %0d addr %h", idx, addr), errs);
    endtask

    task automatic run_all();
        int errs;
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        errs = error_count;
        if (req_ready !== 1'b1) begin
            report_error("req_ready not high after reset");
        end
        if (rsp_valid !== 1'b0) begin
            report_error("rsp_valid not low after reset");
        end
        if (mem_req_valid !== 1'b0) begin
            report_error("mem_req_valid not low after reset");
        end
        finish_test("reset_outputs", errs);
        for (int i = 0; i < fetch_addr.size(); i++) begin
            run_fetch(i);
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin : stimulus
        int seed;
        bit file_ok;
        seed = 2;
        void'($urandom(seed));
        rst       <= 1'b1;
        req_valid <= 1'b0;
        req_addr  <= '0;
        rsp_ready <= 1'b1;
        load_fetches(file_ok);
        if (!file_ok) begin
            $display("test data file missing or without fetch lines");
            $display("** FAIL **");
            $finish;
        end else begin
            run_all();
        end
    end

    // line memory: word at byte address a reads as a ^ A5A50000
    initial begin : memory_model
        int          delay;
        logic [31:0] line_addr;
        mem_req_ready <= 1'b0;
        mem_rsp_valid <= 1'b0;
        mem_rsp_data  <= '0;
        forever begin
            @(posedge clk);
            if (rst === 1'b0 && mem_req_valid === 1'b1) begin
                delay = $urandom % 4;
                repeat (delay) @(posedge clk);
                mem_req_ready <= 1'b1;
                @(posedge clk);
                // request taken on this edge
                mem_req_ready <= 1'b0;
                line_addr      = mem_req_addr;
                last_mem_addr  = line_addr;
                mem_req_count++;
                delay = 1 + $urandom % 6;
                repeat (delay - 1) @(posedge clk);
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= {(line_addr + 32'd4) ^ 32'hA5A50000,
                                  line_addr ^ 32'hA5A50000};
                @(posedge clk);
                mem_rsp_valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (loaded === 1'b1);
        limit = CYCLES_PER_FETCH * fetch_addr.size();
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: verification/icache_testdata.txt
// columns: fetch address, expected word, refill flag (1 = fetch must request a line)
// set 5 cycles through tags 0x8, 0x10 and 0x18 to exercise LRU replacement
00001028 A5A51028 1
0000102C A5A5102C 0
00001028 A5A51028 0
00002028 A5A52028 1
0000202C A5A5202C 0
00001028 A5A51028 0
0000202C A5A5202C 0
00003028 A5A53028 1
0000202C A5A5202C 0
0000302C A5A5302C 0
00001028 A5A51028 1
0000302C A5A5302C 0
00002028 A5A52028 1
0000102C A5A5102C 1
00002028 A5A52028 0
00000100 A5A50100 1
00000104 A5A50104 0
00000108 A5A50108 1
0000010C A5A5010C 0
00000100 A5A50100 0
80000000 25A50000 1
80000004 25A50004 0
FFFFFFFC 5A5AFFFC 1
FFFFFFF8 5A5AFFF8 0
000001F8 A5A501F8 1
FFFFFFFC 5A5AFFFC 0
000001FC A5A501FC 0
